// ==== vlog.f ====
+incdir+include
src/rv32i_pkg.sv
src/register_file.sv
src/forwarding_unit.sv
src/decode_stage.sv
src/execute_stage.sv
src/rv32i_core.sv
tb/rv32i_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the RV32I pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -f vlog.f --top-module rv32i_core_tb \
    --Mdir "$BUILD_DIR" -o rv32i_core_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/rv32i_core_sim" > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Testbench failed" "$SIM_LOG"; then
    exit 1
fi
exit 0

// ==== tb/rv32i_core_tb.sv ====
// Random instruction stream testbench for the RV32I pipeline, checked against an in-order model
`timescale 1ns/1ns
`include "rv32i_defines.svh"

module rv32i_core_tb;
    import rv32i_pkg::*;

    localparam int NUM_INSTS   = 3000;
    localparam int DRAIN_LIMIT = 20;

    logic      clk;
    logic      reset;
    word_t     inst;
    logic      inst_valid;
    logic      wb_valid;
    reg_addr_t wb_rd;
    word_t     wb_result;
    word_t     ex_result;

    // Architectural state, updated in program order
    word_t     model_regs [`RV_NUM_REGS];
    // Expected writebacks, oldest first
    word_t     exp_result_q [$];
    reg_addr_t exp_rd_q [$];

    // ALU result expected in execute at the next falling edge
    logic      ex_pending;
    word_t     ex_expected;

    int errors;
    int wb_count;
    int accepted;
    int drain_cycles;

    rv32i_core i_dut (
        .clk(clk),
        .reset(reset),
        .inst(inst),
        .inst_valid(inst_valid),
        .wb_valid(wb_valid),
        .wb_rd(wb_rd),
        .wb_result(wb_result),
        .ex_result(ex_result)
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    // RV32I integer semantics by funct3, alt selects SUB or SRA
    function automatic word_t model_alu(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
        logic signed [31:0] sa;
        logic [4:0]         sh;
        sa = a;
        sh = b[4:0];
        case (f3)
            `RV_F3_ADD_SUB: return alt ? (a - b) : (a + b);
            `RV_F3_SLL:     return a << sh;
            `RV_F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `RV_F3_SLTU:    return (a < b) ? 32'd1 : 32'd0;
            `RV_F3_XOR:     return a ^ b;
            `RV_F3_SR: begin
                // Arithmetic shift keeps the sign
                if (alt)
                    return sa >>> sh;
                return a >> sh;
            end
            `RV_F3_OR:      return a | b;
            default:        return a & b;
        endcase
    endfunction

    // Record one retiring instruction, x0 stays zero in the model
    task automatic expect_write(input reg_addr_t rd, input word_t value);
        exp_rd_q.push_back(rd);
        exp_result_q.push_back(value);
        accepted++;
        ex_pending  = 1'b1;
        ex_expected = value;
        if (rd != '0)
            model_regs[rd] = value;
    endtask

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_rd(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%02h expected 0x%02h", name, got, exp);
            errors++;
        end
    endtask

    // Outputs are stable at the falling edge, one pop per writeback
    task automatic check_writeback;
        if (wb_valid === 1'b1) begin
            wb_count++;
            if (exp_result_q.size() == 0) begin
                $display("Writeback to x%0d seen with no instruction left to retire", wb_rd);
                errors++;
            end else begin
                check_rd("wb_rd", wb_rd, exp_rd_q.pop_front());
                check_word("wb_result", wb_result, exp_result_q.pop_front());
            end
        end
    endtask

    // Instruction driven on the last falling edge sits in execute at this one
    task automatic next_cycle;
        @(negedge clk);
        check_writeback();
        if (ex_pending)
            check_word("ex_result", ex_result, ex_expected);
        ex_pending = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    // One random slot: idle, unsupported, OP, OP_IMM or LUI over x0 to x7
    task automatic issue_random;
        int          kind;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic        alt;
        logic [11:0] imm12;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        kind  = $urandom_range(0, 19);
        rd    = reg_addr_t'($urandom_range(0, 7));
        rs1   = reg_addr_t'($urandom_range(0, 7));
        rs2   = reg_addr_t'($urandom_range(0, 7));
        f3    = 3'($urandom_range(0, 7));
        alt   = ((f3 == `RV_F3_ADD_SUB) || (f3 == `RV_F3_SR)) && ($urandom_range(0, 1) == 1);
        imm12 = 12'($urandom);
        inst_valid = 1'b1;
        if (kind < 2) begin
            // Idle slot with junk on the bus
            inst_valid = 1'b0;
            inst       = $urandom;
        end else if (kind < 3) begin
            opc = 7'($urandom);
            // Move a supported opcode out of the kept set
            if ((opc == `RV_OPC_OP) || (opc == `RV_OPC_OP_IMM) || (opc == `RV_OPC_LUI))
                opc = opc ^ 7'b100_0000;
            inst = {25'($urandom), opc};
        end else if (kind < 10) begin
            inst = {(alt ? `RV_F7_ALT : 7'b0), rs2, rs1, f3, rd, `RV_OPC_OP};
            expect_write(rd, model_alu(f3, alt, model_regs[rs1], model_regs[rs2]));
        end else if (kind < 17) begin
            // Shift immediates carry funct7 in the top bits
            if (f3 == `RV_F3_SLL)
                imm12[11:5] = 7'b0;
            if (f3 == `RV_F3_SR)
                imm12[11:5] = alt ? `RV_F7_ALT : 7'b0;
            inst = {imm12, rs1, f3, rd, `RV_OPC_OP_IMM};
            expect_write(rd, model_alu(f3, alt && (f3 == `RV_F3_SR), model_regs[rs1],
                                       {{20{imm12[11]}}, imm12}));
        end else begin
            inst = {imm12, rs1, f3, rd, `RV_OPC_LUI};
            expect_write(rd, {inst[31:12], 12'b0});
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        inst        = '0;
        inst_valid  = 1'b0;
        errors      = 0;
        wb_count    = 0;
        accepted    = 0;
        ex_pending  = 1'b0;
        ex_expected = '0;
        for (int i = 0; i < `RV_NUM_REGS; i++)
            model_regs[i] = '0;
        void'($urandom(32'hea48_2677));

        // Two rising edges in reset
        repeat (2) next_cycle();
        reset = 1'b0;
        // Quiet cycles, no writeback may appear here
        repeat (4) next_cycle();

        for (int n = 0; n < NUM_INSTS; n++) begin
            issue_random();
            next_cycle();
        end
        inst_valid = 1'b0;
        inst       = '0;

        // Drain what is still in flight
        drain_cycles = 0;
        while ((exp_result_q.size() != 0) && (drain_cycles < DRAIN_LIMIT)) begin
            next_cycle();
            drain_cycles++;
        end
        if (exp_result_q.size() != 0) begin
            $display("Timed out with %0d writebacks still missing", exp_result_q.size());
            errors++;
        end
        repeat (4) next_cycle();

        if (wb_count != accepted) begin
            $display("Saw %0d writebacks for %0d accepted instructions", wb_count, accepted);
            errors++;
        end
        $display("Errors: %0d, writebacks: %0d, accepted instructions: %0d",
                 errors, wb_count, accepted);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

// ==== src/rv32i_core.sv ====
// Top of the RV32I pipeline, connects decode, register file, forwarding and execute
`timescale 1ns/1ns

module rv32i_core (
    input  logic                 clk,
    input  logic                 reset,
    input  rv32i_pkg::word_t     inst,
    input  logic                 inst_valid,

    // Observability
    output logic                 wb_valid,
    output rv32i_pkg::reg_addr_t wb_rd,
    output rv32i_pkg::word_t     wb_result,
    output rv32i_pkg::word_t     ex_result
);
    import rv32i_pkg::*;

    // ------------------------------------------------------------------
    // Register file read path
    // ------------------------------------------------------------------
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;

    // ------------------------------------------------------------------
    // ID/EX outputs
    // ------------------------------------------------------------------
    logic      id_ex_valid;
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    reg_addr_t id_rd;
    word_t     id_rs1_data;
    word_t     id_rs2_data;
    word_t     id_imm;
    alu_op_t   id_alu_op;
    logic      id_use_imm;

    // Forwarded operands
    word_t     op_a;
    word_t     op_b;

    decode_stage decode_inst (
        .clk(clk),
        .reset(reset),
        .inst(inst),
        .inst_valid(inst_valid),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .id_ex_valid(id_ex_valid),
        .id_rs1(id_rs1),
        .id_rs2(id_rs2),
        .id_rd(id_rd),
        .id_rs1_data(id_rs1_data),
        .id_rs2_data(id_rs2_data),
        .id_imm(id_imm),
        .id_alu_op(id_alu_op),
        .id_use_imm(id_use_imm)
    );

    // Written from writeback, read by the instruction in decode
    register_file register_file_inst (
        .clk(clk),
        .reset(reset),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wr_en(wb_valid),
        .wr_addr(wb_rd),
        .wr_data(wb_result)
    );

    forwarding_unit forwarding_inst (
        .rs1(id_rs1),
        .rs2(id_rs2),
        .rs1_data(id_rs1_data),
        .rs2_data(id_rs2_data),
        .wb_valid(wb_valid),
        .wb_rd(wb_rd),
        .wb_result(wb_result),
        .op_a(op_a),
        .op_b(op_b)
    );

    execute_stage execute_inst (
        .clk(clk),
        .reset(reset),
        .id_ex_valid(id_ex_valid),
        .id_rd(id_rd),
        .op_a(op_a),
        .op_b(op_b),
        .id_imm(id_imm),
        .id_alu_op(id_alu_op),
        .id_use_imm(id_use_imm),
        .ex_result(ex_result),
        .wb_valid(wb_valid),
        .wb_rd(wb_rd),
        .wb_result(wb_result)
    );

endmodule

// ==== src/execute_stage.sv ====
// Execute stage, second operand select and ALU, with the EX/WB register feeding writeback
`timescale 1ns/1ns

module execute_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 id_ex_valid,
    input  rv32i_pkg::reg_addr_t id_rd,
    input  rv32i_pkg::word_t     op_a,
    input  rv32i_pkg::word_t     op_b,
    input  rv32i_pkg::word_t     id_imm,
    input  rv32i_pkg::alu_op_t   id_alu_op,
    input  logic                 id_use_imm,
    output rv32i_pkg::word_t     ex_result,
    output logic                 wb_valid,
    output rv32i_pkg::reg_addr_t wb_rd,
    output rv32i_pkg::word_t     wb_result
);
    import rv32i_pkg::*;

    word_t      alu_b;
    logic [4:0] shamt;

    // ------------------------------------------------------------------
    // Operand select
    // ------------------------------------------------------------------

    // Immediate replaces rs2 for OP_IMM and LUI
    assign alu_b = id_use_imm ? id_imm : op_b;
    // Shifts only look at the low five bits
    assign shamt = alu_b[4:0];

    // ------------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------------
    always_comb begin
        case (id_alu_op)
            ALU_ADD:
                ex_result = op_a + alu_b;
            ALU_SUB:
                ex_result = op_a - alu_b;
            ALU_SLL:
                ex_result = op_a << shamt;
            // Signed compare
            ALU_SLT:
                ex_result = {31'b0, $signed(op_a) < $signed(alu_b)};
            // Unsigned compare
            ALU_SLTU:
                ex_result = {31'b0, op_a < alu_b};
            ALU_XOR:
                ex_result = op_a ^ alu_b;
            ALU_SRL:
                ex_result = op_a >> shamt;
            ALU_SRA:
                ex_result = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:
                ex_result = op_a | alu_b;
            ALU_AND:
                ex_result = op_a & alu_b;
            ALU_PASS_B:
                ex_result = alu_b;
            default:
                ex_result = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // EX/WB register
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset)
            wb_valid <= 1'b0;
        else
            wb_valid <= id_ex_valid;
    end

    always_ff @(posedge clk) begin
        wb_rd     <= id_rd;
        wb_result <= ex_result;
    end

endmodule

// ==== src/decode_stage.sv ====
// Decode stage, splits the instruction, builds immediate and ALU op, and holds the ID/EX register
`timescale 1ns/1ns
`include "rv32i_defines.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  rv32i_pkg::word_t     inst,
    input  logic                 inst_valid,
    output rv32i_pkg::reg_addr_t rs1_addr,
    output rv32i_pkg::reg_addr_t rs2_addr,
    input  rv32i_pkg::word_t     rs1_data,
    input  rv32i_pkg::word_t     rs2_data,
    output logic                 id_ex_valid,
    output rv32i_pkg::reg_addr_t id_rs1,
    output rv32i_pkg::reg_addr_t id_rs2,
    output rv32i_pkg::reg_addr_t id_rd,
    output rv32i_pkg::word_t     id_rs1_data,
    output rv32i_pkg::word_t     id_rs2_data,
    output rv32i_pkg::word_t     id_imm,
    output rv32i_pkg::alu_op_t   id_alu_op,
    output logic                 id_use_imm
);
    import rv32i_pkg::*;

    // Instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    word_t      imm_i;
    word_t      imm_u;

    // Decoded controls
    alu_op_t    dec_op;
    word_t      dec_imm;
    logic       dec_use_imm;
    logic       dec_ok;

    // funct3 to ALU op, alt picks SUB or SRA
    function automatic alu_op_t op_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            `RV_F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            `RV_F3_SLL:     return ALU_SLL;
            `RV_F3_SLT:     return ALU_SLT;
            `RV_F3_SLTU:    return ALU_SLTU;
            `RV_F3_XOR:     return ALU_XOR;
            `RV_F3_SR:      return alt ? ALU_SRA : ALU_SRL;
            `RV_F3_OR:      return ALU_OR;
            default:        return ALU_AND;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // Field split and immediates
    // ------------------------------------------------------------------
    assign opcode   = inst[6:0];
    assign rd       = inst[11:7];
    assign funct3   = inst[14:12];
    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];
    assign funct7   = inst[31:25];

    // Sign-extended I immediate, low five bits double as shamt
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    // U immediate with zero low bits
    assign imm_u = {inst[31:12], 12'b0};

    // ------------------------------------------------------------------
    // Control decode
    // ------------------------------------------------------------------
    always_comb begin
        dec_op      = ALU_ADD;
        dec_imm     = imm_i;
        dec_use_imm = 1'b0;
        dec_ok      = 1'b0;
        case (opcode)
            `RV_OPC_OP: begin
                // Alternate funct7 only legal for SUB and SRA
                dec_ok = (funct7 == '0) ||
                         ((funct7 == `RV_F7_ALT) &&
                          ((funct3 == `RV_F3_ADD_SUB) || (funct3 == `RV_F3_SR)));
                dec_op = op_from_funct3(funct3, funct7 == `RV_F7_ALT);
            end
            `RV_OPC_OP_IMM: begin
                dec_use_imm = 1'b1;
                dec_ok      = 1'b1;
                // Shift kind from funct7, other ops ignore it
                if (funct3 == `RV_F3_SLL)
                    dec_ok = (funct7 == '0);
                if (funct3 == `RV_F3_SR)
                    dec_ok = (funct7 == '0) || (funct7 == `RV_F7_ALT);
                dec_op = op_from_funct3(funct3,
                                        (funct3 == `RV_F3_SR) && (funct7 == `RV_F7_ALT));
            end
            `RV_OPC_LUI: begin
                dec_op      = ALU_PASS_B;
                dec_imm     = imm_u;
                dec_use_imm = 1'b1;
                dec_ok      = 1'b1;
            end
            default: begin
                // Unsupported opcode never retires
                dec_ok = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset)
            id_ex_valid <= 1'b0;
        else
            id_ex_valid <= inst_valid && dec_ok;
    end

    always_ff @(posedge clk) begin
        id_rs1      <= rs1_addr;
        id_rs2      <= rs2_addr;
        id_rd       <= rd;
        id_rs1_data <= rs1_data;
        id_rs2_data <= rs2_data;
        id_imm      <= dec_imm;
        id_alu_op   <= dec_op;
        id_use_imm  <= dec_use_imm;
    end

endmodule

// ==== src/forwarding_unit.sv ====
// Operand forwarding from writeback into execute, sits beside the register file in the core
`timescale 1ns/1ns

module forwarding_unit (
    input  rv32i_pkg::reg_addr_t rs1,
    input  rv32i_pkg::reg_addr_t rs2,
    input  rv32i_pkg::word_t     rs1_data,
    input  rv32i_pkg::word_t     rs2_data,
    input  logic                 wb_valid,
    input  rv32i_pkg::reg_addr_t wb_rd,
    input  rv32i_pkg::word_t     wb_result,
    output rv32i_pkg::word_t     op_a,
    output rv32i_pkg::word_t     op_b
);
    import rv32i_pkg::*;

    // Operand select
    // Writeback result when it targets this source, x0 never forwards
    function automatic word_t pick(input reg_addr_t src, input word_t reg_val);
        logic hit;
        hit = wb_valid && (wb_rd == src) && (src != '0);
        return hit ? wb_result : reg_val;
    endfunction

    // ------------------------------------------------------------------
    // Operands for execute
    // ------------------------------------------------------------------

    // Value captured in ID/EX is stale by one instruction at most
    always_comb begin
        op_a = pick(rs1, rs1_data);
        op_b = pick(rs2, rs2_data);
    end

endmodule

// ==== src/register_file.sv ====
// 32-entry register file with two combinational reads and a write-through bypass, used by the core
`timescale 1ns/1ns
`include "rv32i_defines.svh"

module register_file (
    input  logic                 clk,
    input  logic                 reset,
    input  rv32i_pkg::reg_addr_t rs1_addr,
    input  rv32i_pkg::reg_addr_t rs2_addr,
    output rv32i_pkg::word_t     rs1_data,
    output rv32i_pkg::word_t     rs2_data,
    input  logic                 wr_en,
    input  rv32i_pkg::reg_addr_t wr_addr,
    input  rv32i_pkg::word_t     wr_data
);
    import rv32i_pkg::*;

    word_t regs [`RV_NUM_REGS];

    // Read port logic
    // x0 is hard zero, a write in flight to the same index wins
    function automatic word_t read_port(input reg_addr_t addr);
        if (addr == '0)
            return '0;
        else if (wr_en && (wr_addr == addr))
            return wr_data;
        else
            return regs[addr];
    endfunction

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            // Writes to x0 are dropped
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

// ==== src/rv32i_pkg.sv ====
// Shared data, register index and ALU operation types, imported by the pipeline stages
`include "rv32i_defines.svh"

package rv32i_pkg;

    // ------------------------------------------------------------------
    // Datapath types
    // ------------------------------------------------------------------

    // One register or ALU word
    typedef logic [`RV_XLEN-1:0] word_t;

    // Register file index, x0 to x31
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // ------------------------------------------------------------------
    // ALU operations
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        // Second operand straight through, for LUI
        ALU_PASS_B = 4'd10
    } alu_op_t;

endpackage

// ==== include/rv32i_defines.svh ====
// Widths, opcodes and funct codes of the RV32I pipeline, included by the package and the stages
`ifndef RV32I_DEFINES_SVH
`define RV32I_DEFINES_SVH

// ------------------------------------------------------------------
// Widths
// ------------------------------------------------------------------
`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_NUM_REGS    32

// ------------------------------------------------------------------
// Opcodes of the supported instruction classes
// ------------------------------------------------------------------
`define RV_OPC_OP      7'b011_0011
`define RV_OPC_OP_IMM  7'b001_0011
`define RV_OPC_LUI     7'b011_0111

// ------------------------------------------------------------------
// funct3 values, shared by register and immediate forms
// ------------------------------------------------------------------
`define RV_F3_ADD_SUB  3'b000
`define RV_F3_SLL      3'b001
`define RV_F3_SLT      3'b010
`define RV_F3_SLTU     3'b011
`define RV_F3_XOR      3'b100
`define RV_F3_SR       3'b101
`define RV_F3_OR       3'b110
`define RV_F3_AND      3'b111

// Selects SUB over ADD and SRA over SRL
`define RV_F7_ALT      7'b010_0000

`endif
